//--- rtl/obi_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the banked OBI scratchpad
// 32-bit address and data, four byte lanes
// size code 3 is handled as a word by every user
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package obi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // byte address as seen by the core
    typedef logic [ADDR_W-1:0] addr_t;

    // one full data word
    typedef logic [DATA_W-1:0] data_t;

    // one enable per byte lane
    typedef logic [BE_W-1:0] be_t;

    // access size from the core
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // per-bank manager states
    typedef enum logic [1:0] {
        IDLE,
        REQUESTING,
        WAITING,
        DUMPING
    } obi_state_e;

endpackage

//--- rtl/obi_intf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// internal links of the scratchpad
// no clock inside, users sample on their own clk
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// router to manager, one per bank
interface core_req_if import obi_pkg::*; ();
    logic  valid;
    logic  ready;
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;

    modport router  (output valid, addr, we, be, wdata, input ready);
    modport manager (input valid, addr, we, be, wdata, output ready);
endinterface

// manager to merger, one per bank
interface core_resp_if import obi_pkg::*; ();
    logic  valid;
    logic  ready;
    data_t rdata;
    logic  err;

    modport source (output valid, rdata, err, input ready);
    modport sink   (input valid, rdata, err, output ready);
endinterface

// OBI link between a manager and its bank
interface obi_if import obi_pkg::*; ();
    logic  req;
    logic  gnt;
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
    data_t rdata;
    logic  rvalid;
    logic  err;

    modport manager     (output req, addr, we, be, wdata, input gnt, rdata, rvalid, err);
    modport subordinate (input req, addr, we, be, wdata, output gnt, rdata, rvalid, err);
endinterface

//--- rtl/core_req_router.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// purely combinational request steering
// offset bits a size cannot use are ignored without a misalign check
// NUM_BANKS must be a power of two and at least 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module core_req_router import obi_pkg::*; #(
    parameter int NUM_BANKS = 4,
    localparam int IDX_W = $clog2(NUM_BANKS)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              core_valid_i,
    output logic              core_ready_o,
    input  addr_t             core_addr_i,
    input  logic              core_we_i,
    input  size_t             core_size_i,
    input  data_t             core_wdata_i,
    core_req_if.router        mgr_req [NUM_BANKS],
    output logic              order_push_o,
    output logic [IDX_W-1:0]  order_idx_o,
    input  logic              order_full_i
);

    logic [IDX_W-1:0]     bank_idx;
    logic [NUM_BANKS-1:0] bank_ready;
    logic [NUM_BANKS-1:0] bank_valid;
    be_t                  be;
    data_t                wdata;

    // words interleave across banks with the bank bits right above the byte offset
    assign bank_idx = core_addr_i[2 +: IDX_W];

    // lane enables from size and low address bits
    always_comb begin
        case (core_size_i)
            SIZE_BYTE: be = be_t'(4'b0001) << core_addr_i[1:0];
            SIZE_HALF: be = core_addr_i[1] ? 4'b1100 : 4'b0011;
            // word and the spare code 3
            default:   be = 4'b1111;
        endcase
    end

    // replicate narrow data so every lane carries it
    always_comb begin
        case (core_size_i)
            SIZE_BYTE: wdata = {4{core_wdata_i[7:0]}};
            SIZE_HALF: wdata = {2{core_wdata_i[15:0]}};
            default:   wdata = core_wdata_i;
        endcase
    end

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        // valid only toward the addressed bank and held off while the order queue is full
        assign bank_valid[i]      = core_valid_i && !order_full_i
                                    && (bank_idx == IDX_W'(i));
        assign mgr_req[i].valid   = bank_valid[i];
        assign mgr_req[i].addr    = core_addr_i;
        assign mgr_req[i].we      = core_we_i;
        assign mgr_req[i].be      = be;
        assign mgr_req[i].wdata   = wdata;
        assign bank_ready[i]      = mgr_req[i].ready;
    end

    // target manager must be idle and the queue must have room
    assign core_ready_o = bank_ready[bank_idx] && !order_full_i;

    // every accepted request records its bank for the merger
    assign order_push_o = core_valid_i && core_ready_o;
    assign order_idx_o  = bank_idx;

    // a stalled core request keeps its address phase until accepted
    a_core_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (core_valid_i && !core_ready_o) |=> (core_valid_i && $stable(core_addr_i)
            && $stable(core_we_i) && $stable(core_size_i) && $stable(core_wdata_i)));

endmodule

//--- rtl/obi_manager.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OBI manager, one outstanding transfer at a time
// ready toward the router only in IDLE
// response is held in DUMPING until the merger takes it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module obi_manager import obi_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    core_req_if.manager req,
    core_resp_if.source resp,
    obi_if.manager      obi
);

    obi_state_e state_q;
    obi_state_e state_d;

    // address phase copy for replay in REQUESTING
    addr_t addr_q;
    logic  we_q;
    be_t   be_q;
    data_t wdata_q;

    // captured response for DUMPING
    data_t rdata_q;
    logic  err_q;

    always_comb begin
        state_d    = state_q;
        req.ready  = 1'b0;
        resp.valid = 1'b0;
        resp.rdata = rdata_q;
        resp.err   = err_q;
        obi.req    = 1'b0;
        obi.addr   = addr_q;
        obi.we     = we_q;
        obi.be     = be_q;
        obi.wdata  = wdata_q;

        case (state_q)
            IDLE: begin
                // straight through, no extra cycle on a free bank
                req.ready = 1'b1;
                obi.req   = req.valid;
                obi.addr  = req.addr;
                obi.we    = req.we;
                obi.be    = req.be;
                obi.wdata = req.wdata;
                if (req.valid) begin
                    state_d = obi.gnt ? WAITING : REQUESTING;
                end
            end
            REQUESTING: begin
                // replay registered phase until grant
                obi.req = 1'b1;
                if (obi.gnt) begin
                    state_d = WAITING;
                end
            end
            WAITING: begin
                // rvalid is offered to the merger in the same cycle
                if (obi.rvalid) begin
                    resp.valid = 1'b1;
                    resp.rdata = obi.rdata;
                    resp.err   = obi.err;
                    state_d    = resp.ready ? IDLE : DUMPING;
                end
            end
            DUMPING: begin
                resp.valid = 1'b1;
                if (resp.ready) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (state_q == IDLE && req.valid) begin
            addr_q  <= req.addr;
            we_q    <= req.we;
            be_q    <= req.be;
            wdata_q <= req.wdata;
        end
        if (state_q == WAITING && obi.rvalid) begin
            rdata_q <= obi.rdata;
            err_q   <= obi.err;
        end
    end

    // OBI rule, request and address phase held until grant
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (obi.req && !obi.gnt) |=> (obi.req && $stable(obi.addr) && $stable(obi.we)
                                   && $stable(obi.be) && $stable(obi.wdata)));

    // bank answers only what this manager issued
    a_no_stray_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        !(state_q == IDLE && obi.rvalid));

endmodule

//--- rtl/obi_sram_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-port SRAM behind an OBI subordinate port
// gnt drops only in the cycle rvalid is returned
// bank-select bits are not checked since the router decoded them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module obi_sram_bank import obi_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 64,
    localparam int IDX_W  = $clog2(NUM_BANKS),
    localparam int WORD_W = $clog2(BANK_WORDS),
    localparam int TOP_LO = 2 + IDX_W + WORD_W
) (
    input  logic          clk,
    input  logic          rst_n,
    obi_if.subordinate    obi
);

    data_t             mem [BANK_WORDS];
    logic [WORD_W-1:0] word_idx;
    logic              in_range;
    logic              accept;
    logic              rvalid_q;
    data_t             rdata_q;
    logic              err_q;

    // word index sits above the bank bits
    assign word_idx = obi.addr[2 + IDX_W +: WORD_W];
    // anything above the last word of the last bank is out of range
    assign in_range = (obi.addr[ADDR_W-1:TOP_LO] == '0);

    assign obi.gnt = !rvalid_q;
    assign accept  = obi.req && obi.gnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= accept;
        end
    end

    // response data and memory update
    always_ff @(posedge clk) begin
        if (accept) begin
            err_q   <= !in_range;
            // writes and errors return zero
            rdata_q <= (in_range && !obi.we) ? mem[word_idx] : '0;
            if (in_range && obi.we) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (obi.be[b]) begin
                        mem[word_idx][b*8 +: 8] <= obi.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    assign obi.rvalid = rvalid_q;
    assign obi.rdata  = rdata_q;
    assign obi.err    = err_q;

    // one transfer in flight so no new request while the response returns
    a_no_req_on_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        obi.rvalid |-> !obi.req);

endmodule

//--- rtl/resp_merger.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in-order response return across banks
// queue depth equals NUM_BANKS with one slot per manager
// pushes must be held off by the caller while full
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module resp_merger import obi_pkg::*; #(
    parameter int NUM_BANKS = 4,
    localparam int IDX_W = $clog2(NUM_BANKS)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              order_push_i,
    input  logic [IDX_W-1:0]  order_idx_i,
    output logic              order_full_o,
    core_resp_if.sink         mgr_resp [NUM_BANKS],
    output logic              resp_valid_o,
    input  logic              resp_ready_i,
    output data_t             resp_rdata_o,
    output logic              resp_err_o
);

    logic [IDX_W-1:0]     order_q [NUM_BANKS];
    logic [IDX_W-1:0]     wr_ptr_q;
    logic [IDX_W-1:0]     rd_ptr_q;
    logic [IDX_W:0]       count_q;
    logic                 empty;
    logic                 pop;
    logic [IDX_W-1:0]     head_idx;
    logic [NUM_BANKS-1:0] mgr_valid;
    logic [NUM_BANKS-1:0] mgr_err;
    data_t                mgr_rdata [NUM_BANKS];

    assign empty        = (count_q == '0);
    assign order_full_o = (count_q == (IDX_W+1)'(NUM_BANKS));
    assign head_idx     = order_q[rd_ptr_q];

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_mgr
        assign mgr_valid[i] = mgr_resp[i].valid;
        assign mgr_rdata[i] = mgr_resp[i].rdata;
        assign mgr_err[i]   = mgr_resp[i].err;
        // only the oldest outstanding bank may hand over its response
        assign mgr_resp[i].ready = !empty && (head_idx == IDX_W'(i)) && resp_ready_i;
    end

    assign resp_valid_o = !empty && mgr_valid[head_idx];
    assign resp_rdata_o = mgr_rdata[head_idx];
    assign resp_err_o   = mgr_err[head_idx];

    // pop together with the handshake on the head response
    assign pop = resp_valid_o && resp_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // pointers wrap on their own since depth is a power of two
            if (order_push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (IDX_W+1)'(order_push_i) - (IDX_W+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (order_push_i) begin
            order_q[wr_ptr_q] <= order_idx_i;
        end
    end

    // no push beyond the depth and no response without a queued bank
    a_queue_bounds: assert property (@(posedge clk) disable iff (!rst_n)
        !(order_push_i && order_full_o) && !(empty && (|mgr_valid)));

endmodule

//--- rtl/obi_scratchpad.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// banked scratchpad for a core data port
// NUM_BANKS and BANK_WORDS must both be powers of two
// responses return in acceptance order, full words only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module obi_scratchpad import obi_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 64,
    localparam int IDX_W = $clog2(NUM_BANKS)
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  core_valid_i,
    output logic  core_ready_o,
    input  addr_t core_addr_i,
    input  logic  core_we_i,
    input  size_t core_size_i,
    input  data_t core_wdata_i,
    output logic  resp_valid_o,
    input  logic  resp_ready_i,
    output data_t resp_rdata_o,
    output logic  resp_err_o
);

    // per-bank links
    core_req_if  req_link  [NUM_BANKS] ();
    core_resp_if resp_link [NUM_BANKS] ();
    obi_if       obi_link  [NUM_BANKS] ();

    // issue order from router to merger
    logic             order_push;
    logic [IDX_W-1:0] order_idx;
    logic             order_full;

    core_req_router #(
        .NUM_BANKS (NUM_BANKS)
    ) core_req_router_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_valid_i (core_valid_i),
        .core_ready_o (core_ready_o),
        .core_addr_i  (core_addr_i),
        .core_we_i    (core_we_i),
        .core_size_i  (core_size_i),
        .core_wdata_i (core_wdata_i),
        .mgr_req      (req_link),
        .order_push_o (order_push),
        .order_idx_o  (order_idx),
        .order_full_i (order_full)
    );

    // one manager and one SRAM per bank
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        obi_manager obi_manager_i (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (req_link[g]),
            .resp  (resp_link[g]),
            .obi   (obi_link[g])
        );

        obi_sram_bank #(
            .NUM_BANKS  (NUM_BANKS),
            .BANK_WORDS (BANK_WORDS)
        ) obi_sram_bank_i (
            .clk   (clk),
            .rst_n (rst_n),
            .obi   (obi_link[g])
        );
    end

    resp_merger #(
        .NUM_BANKS (NUM_BANKS)
    ) resp_merger_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .order_push_i (order_push),
        .order_idx_i  (order_idx),
        .order_full_o (order_full),
        .mgr_resp     (resp_link),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_rdata_o (resp_rdata_o),
        .resp_err_o   (resp_err_o)
    );

endmodule

//--- tb/tb_obi_scratchpad.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the scratchpad with 4 banks of 64 words
// expected values are hand-worked in the stimulus table
// resp_ready_i stalls come from a fixed-seed LFSR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_obi_scratchpad import obi_pkg::*; ();

    localparam int READY_LIMIT = 50;
    localparam int RESP_LIMIT  = 200;

    // one table row where writes expect zero rdata
    typedef struct {
        string name;
        logic  we;
        size_t size;
        addr_t addr;
        data_t wdata;
        data_t exp_rdata;
        logic  exp_err;
    } vec_t;

    logic  clk;
    logic  rst_n;
    logic  core_valid_i;
    logic  core_ready_o;
    addr_t core_addr_i;
    logic  core_we_i;
    size_t core_size_i;
    data_t core_wdata_i;
    logic  resp_valid_o;
    logic  resp_ready_i;
    data_t resp_rdata_o;
    logic  resp_err_o;

    vec_t        vectors [$];
    logic [31:0] lfsr;

    obi_scratchpad #(
        .NUM_BANKS  (4),
        .BANK_WORDS (64)
    ) obi_scratchpad_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_valid_i (core_valid_i),
        .core_ready_o (core_ready_o),
        .core_addr_i  (core_addr_i),
        .core_we_i    (core_we_i),
        .core_size_i  (core_size_i),
        .core_wdata_i (core_wdata_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_rdata_o (resp_rdata_o),
        .resp_err_o   (resp_err_o)
    );

    always #5 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s rdata expected %08h actual %08h", name, exp, act));
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s err expected %0b actual %0b", name, exp, act));
        end
    endtask

    // handshake levels outside any transfer
    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic add_vec(input string name, input logic we, input size_t size,
                           input addr_t addr, input data_t wdata,
                           input data_t exp_rdata, input logic exp_err);
        vec_t v;
        v.name      = name;
        v.we        = we;
        v.size      = size;
        v.addr      = addr;
        v.wdata     = wdata;
        v.exp_rdata = exp_rdata;
        v.exp_err   = exp_err;
        vectors.push_back(v);
    endtask

    // bank in addr[3:2] and word in addr[9:4] below a limit of 1024
    task automatic build_table();
        add_vec("wr_b0",      1, SIZE_WORD, 32'h000, 32'h1111_1111, 32'h0, 0);
        add_vec("wr_b1",      1, SIZE_WORD, 32'h004, 32'h2222_2222, 32'h0, 0);
        add_vec("wr_b2",      1, SIZE_WORD, 32'h008, 32'h3333_3333, 32'h0, 0);
        add_vec("wr_b3_last", 1, SIZE_WORD, 32'h3fc, 32'h4444_4444, 32'h0, 0);
        add_vec("rd_b0",      0, SIZE_WORD, 32'h000, 32'h0, 32'h1111_1111, 0);
        add_vec("rd_b1",      0, SIZE_WORD, 32'h004, 32'h0, 32'h2222_2222, 0);
        add_vec("rd_b2",      0, SIZE_WORD, 32'h008, 32'h0, 32'h3333_3333, 0);
        add_vec("rd_b3_last", 0, SIZE_WORD, 32'h3fc, 32'h0, 32'h4444_4444, 0);
        // byte lanes over a whole base word, each step read back
        add_vec("wr_base_b",  1, SIZE_WORD, 32'h010, 32'haabb_ccdd, 32'h0, 0);
        add_vec("wr_byte0",   1, SIZE_BYTE, 32'h010, 32'hffff_ff11, 32'h0, 0);
        add_vec("rd_byte0",   0, SIZE_WORD, 32'h010, 32'h0, 32'haabb_cc11, 0);
        add_vec("wr_byte1",   1, SIZE_BYTE, 32'h011, 32'h0000_0022, 32'h0, 0);
        add_vec("rd_byte1",   0, SIZE_WORD, 32'h010, 32'h0, 32'haabb_2211, 0);
        add_vec("wr_byte2",   1, SIZE_BYTE, 32'h012, 32'h0000_0033, 32'h0, 0);
        add_vec("rd_byte2",   0, SIZE_WORD, 32'h010, 32'h0, 32'haa33_2211, 0);
        add_vec("wr_byte3",   1, SIZE_BYTE, 32'h013, 32'h0000_0044, 32'h0, 0);
        add_vec("rd_bytes",   0, SIZE_WORD, 32'h010, 32'h0, 32'h4433_2211, 0);
        // narrow read still returns the full word
        add_vec("rd_byte_sz", 0, SIZE_BYTE, 32'h011, 32'h0, 32'h4433_2211, 0);
        // half words drop the upper junk in wdata
        add_vec("wr_base_h",  1, SIZE_WORD, 32'h014, 32'h1234_5678, 32'h0, 0);
        add_vec("wr_half0",   1, SIZE_HALF, 32'h014, 32'h5555_beef, 32'h0, 0);
        add_vec("rd_half0",   0, SIZE_WORD, 32'h014, 32'h0, 32'h1234_beef, 0);
        add_vec("wr_half2",   1, SIZE_HALF, 32'h016, 32'h0000_cafe, 32'h0, 0);
        add_vec("rd_halves",  0, SIZE_WORD, 32'h014, 32'h0, 32'hcafe_beef, 0);
        // spare size code acts as a word
        add_vec("wr_size3",   1, 2'd3,      32'h0c0, 32'h5a5a_a5a5, 32'h0, 0);
        add_vec("rd_size3",   0, SIZE_WORD, 32'h0c0, 32'h0, 32'h5a5a_a5a5, 0);
        // out of range 0x400 aliases word 0 of bank 0 in its low bits
        add_vec("wr_oor",     1, SIZE_WORD, 32'h400, 32'hdead_beef, 32'h0, 1);
        add_vec("rd_oor",     0, SIZE_WORD, 32'h400, 32'h0, 32'h0, 1);
        add_vec("rd_oor_top", 0, SIZE_WORD, 32'h8000_0000, 32'h0, 32'h0, 1);
        add_vec("rd_alias",   0, SIZE_WORD, 32'h000, 32'h0, 32'h1111_1111, 0);
        // back to back over all four banks
        add_vec("wr_bb0",     1, SIZE_WORD, 32'h020, 32'h0f1e_2d3c, 32'h0, 0);
        add_vec("wr_bb1",     1, SIZE_WORD, 32'h024, 32'h4b5a_6978, 32'h0, 0);
        add_vec("wr_bb2",     1, SIZE_WORD, 32'h028, 32'h8796_a5b4, 32'h0, 0);
        add_vec("wr_bb3",     1, SIZE_WORD, 32'h02c, 32'hc3d2_e1f0, 32'h0, 0);
        add_vec("rd_bb0",     0, SIZE_WORD, 32'h020, 32'h0, 32'h0f1e_2d3c, 0);
        add_vec("rd_bb1",     0, SIZE_WORD, 32'h024, 32'h0, 32'h4b5a_6978, 0);
        add_vec("rd_bb2",     0, SIZE_WORD, 32'h028, 32'h0, 32'h8796_a5b4, 0);
        add_vec("rd_bb3",     0, SIZE_WORD, 32'h02c, 32'h0, 32'hc3d2_e1f0, 0);
    endtask

    // drive on the falling edge and check ready once settled
    task automatic issue_requests();
        int waited;
        foreach (vectors[i]) begin
            @(negedge clk);
            core_valid_i = 1'b1;
            core_we_i    = vectors[i].we;
            core_size_i  = vectors[i].size;
            core_addr_i  = vectors[i].addr;
            core_wdata_i = vectors[i].wdata;
            #1;
            waited = 0;
            while (!core_ready_o) begin
                @(negedge clk);
                #1;
                waited++;
                if (!core_ready_o && waited > READY_LIMIT) begin
                    fail_run($sformatf("timeout: core_ready_o never rose for %s",
                                       vectors[i].name));
                end
            end
            // transfer happens on the coming rising edge
        end
        @(negedge clk);
        core_valid_i = 1'b0;
    endtask

    // responses must come back in table order
    task automatic collect_responses();
        int    waited;
        logic  taken;
        data_t got_rdata;
        logic  got_err;
        foreach (vectors[i]) begin
            waited = 0;
            taken  = 1'b0;
            while (!taken) begin
                @(negedge clk);
                lfsr         = lfsr_step(lfsr);
                resp_ready_i = lfsr[0];
                #1;
                if (resp_valid_o && resp_ready_i) begin
                    got_rdata = resp_rdata_o;
                    got_err   = resp_err_o;
                    taken     = 1'b1;
                end else begin
                    waited++;
                    if (waited > RESP_LIMIT) begin
                        fail_run($sformatf("timeout: no response arrived for %s",
                                           vectors[i].name));
                    end
                end
            end
            check_data(vectors[i].name, vectors[i].exp_rdata, got_rdata);
            check_err(vectors[i].name, vectors[i].exp_err, got_err);
        end
        @(negedge clk);
        resp_ready_i = 1'b0;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        core_valid_i = 1'b0;
        core_addr_i  = '0;
        core_we_i    = 1'b0;
        core_size_i  = SIZE_WORD;
        core_wdata_i = '0;
        resp_ready_i = 1'b0;
        lfsr         = 32'ha4f5;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        // idle levels before the first request
        check_flag("reset_resp_valid", 1'b0, resp_valid_o);
        check_flag("reset_core_ready", 1'b1, core_ready_o);
        fork
            issue_requests();
            collect_responses();
        join
        $display("No errors");
        $finish;
    end

endmodule

//--- obi_scratchpad.f
rtl/obi_pkg.sv
rtl/obi_intf.sv
rtl/core_req_router.sv
rtl/obi_manager.sv
rtl/obi_sram_bank.sv
rtl/resp_merger.sv
rtl/obi_scratchpad.sv
tb/tb_obi_scratchpad.sv

//--- run_sim.sh
#!/bin/sh
# build the scratchpad testbench with Verilator and run it
# exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_obi_scratchpad \
    -f obi_scratchpad.f -o tb_obi_scratchpad \
    && ./obj_dir/tb_obi_scratchpad \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }
